//--- hdl/ahb_loader_config.svh
`ifndef AHB_LOADER_CONFIG_SVH
`define AHB_LOADER_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial link
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// HCLK cycles per UART bit. A real board would use HCLK / baud rate.
`define CLKS_PER_BIT 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Byte address bits of the RAM, 10 bits gives 1 KB.
`define RAM_ADDR_WIDTH 10

// Any address with bit 28 set falls into the GPIO region.
`define GPIO_BASE 32'h1000_0000

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define LED_RED_WIDTH 18
`define LED_GREEN_WIDTH 9
`define SWITCH_WIDTH 18
`define BUTTON_WIDTH 5

`endif

//--- hdl/ahb_loader_pkg.sv
package ahb_loader_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AHB-Lite encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001
    } hburst_t;

    // Address-phase signals of one master.
    typedef struct packed {
        logic [31:0] haddr;
        htrans_t     htrans;
        hsize_t      hsize;
        hburst_t     hburst;
        logic [3:0]  hprot;
        logic        hmastlock;
        logic        hwrite;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_resp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Boot loader
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        WAIT_S,
        TYPE,
        COUNT_HI,
        COUNT_LO,
        ADDR,
        DATA,
        CHECK_HI,
        CHECK_LO,
        END_OF_LINE
    } srec_state_t;

    typedef struct packed {
        logic       in_progress;
        logic       format_error;
        logic       checksum_error;
        logic [7:0] error_location;
    } loader_status_t;

    typedef struct packed {
        logic [31:0] address;
        logic [7:0]  data;
        logic        enable;
    } mem_write_t;

endpackage

//--- hdl/uart_receiver.sv
`timescale 1ns/1ns
`include "ahb_loader_config.svh"

module uart_receiver (
    input  logic       HCLK,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] char_data,
    output logic       char_ready
);

    localparam int CLKS = `CLKS_PER_BIT;
    localparam int CW   = $clog2(CLKS);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t     state;
    logic          rx_meta;
    logic          rx_sync;
    logic [CW-1:0] clk_count;
    logic [2:0]    bit_index;
    logic [7:0]    shift;
    logic          bit_done;

    assign bit_done = clk_count == CW'(CLKS - 1);

    always_ff @(posedge HCLK) begin
        if (reset) begin
            rx_meta    <= 1'b1;
            rx_sync    <= 1'b1;
            state      <= IDLE;
            char_ready <= 1'b0;
        end else begin
            rx_meta    <= rx;
            rx_sync    <= rx_meta;
            char_ready <= 1'b0;
            case (state)
                IDLE: begin
                    clk_count <= '0;
                    if (!rx_sync)
                        state <= START;
                end
                // Half a bit in, the line must still be low for a real start bit.
                START: begin
                    if (clk_count == CW'(CLKS / 2 - 1)) begin
                        clk_count <= '0;
                        bit_index <= '0;
                        state     <= rx_sync ? IDLE : DATA;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        clk_count <= '0;
                        shift     <= {rx_sync, shift[7:1]};
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7)
                            state <= STOP;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        // A low stop bit is a framing error and the byte is dropped.
                        if (rx_sync) begin
                            char_data  <= shift;
                            char_ready <= 1'b1;
                        end
                        state <= IDLE;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    char_ready_single: assert property (@(posedge HCLK) disable iff (reset)
        char_ready |=> !char_ready);

endmodule

//--- hdl/srec_parser.sv
`timescale 1ns/1ns

module srec_parser
    import ahb_loader_pkg::*;
(
    input  logic           HCLK,
    input  logic           reset,
    input  logic [7:0]     char_data,
    input  logic           char_ready,
    output mem_write_t     wr,
    output loader_status_t status
);

    srec_state_t state;

    logic        is_hex;
    logic        is_eol;
    logic [3:0]  nibble;
    logic [7:0]  byte_value;
    logic        format_fail;
    logic        checksum_fail;

    logic [3:0]  high_nibble;
    logic        low_digit;
    logic        data_record;
    logic        end_record;
    logic [2:0]  addr_len;
    logic [2:0]  addr_left;
    logic [7:0]  remaining;
    logic [7:0]  sum;
    logic [31:0] address;
    logic [7:0]  line_count;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Character decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        is_hex = 1'b1;
        nibble = 4'd0;
        if (char_data >= "0" && char_data <= "9")
            nibble = 4'(char_data - "0");
        else if (char_data >= "A" && char_data <= "F")
            nibble = 4'(char_data - "A" + 8'd10);
        else if (char_data >= "a" && char_data <= "f")
            nibble = 4'(char_data - "a" + 8'd10);
        else
            is_hex = 1'b0;
    end

    assign is_eol     = char_data == 8'h0D || char_data == 8'h0A;
    assign byte_value = {high_nibble, nibble};

    // Line ends inside a record are not hex, so they count as format errors too.
    always_comb begin
        format_fail = 1'b0;
        if (char_ready) begin
            case (state)
                WAIT_S:      format_fail = 1'b0;
                TYPE:        format_fail = !(char_data inside {"0", "1", "3", "7", "9"});
                COUNT_LO:    format_fail = !is_hex || byte_value <= {5'd0, addr_len};
                END_OF_LINE: format_fail = !is_eol;
                default:     format_fail = !is_hex;
            endcase
        end
    end

    assign checksum_fail = char_ready && state == CHECK_LO && is_hex && byte_value != ~sum;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Record FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge HCLK) begin
        wr.enable <= 1'b0;
        if (reset) begin
            state      <= WAIT_S;
            status     <= '0;
            line_count <= '0;
        end else if (format_fail || checksum_fail) begin
            state                 <= WAIT_S;
            status.in_progress    <= 1'b0;
            status.format_error   <= format_fail;
            status.checksum_error <= checksum_fail;
            status.error_location <= line_count;
        end else if (char_ready) begin
            case (state)
                WAIT_S: begin
                    if (char_data == "S") begin
                        state <= TYPE;
                        if (!status.in_progress) begin
                            status     <= '{in_progress: 1'b1, default: '0};
                            line_count <= 8'd1;
                        end else begin
                            line_count <= line_count + 8'd1;
                        end
                    end
                end
                TYPE: begin
                    data_record <= char_data inside {"1", "3"};
                    end_record  <= char_data inside {"7", "9"};
                    addr_len    <= (char_data inside {"3", "7"}) ? 3'd4 : 3'd2;
                    state       <= COUNT_HI;
                end
                COUNT_HI: begin
                    high_nibble <= nibble;
                    state       <= COUNT_LO;
                end
                COUNT_LO: begin
                    sum       <= byte_value;
                    remaining <= byte_value;
                    addr_left <= addr_len;
                    address   <= '0;
                    low_digit <= 1'b0;
                    state     <= ADDR;
                end
                ADDR: begin
                    if (!low_digit) begin
                        high_nibble <= nibble;
                        low_digit   <= 1'b1;
                    end else begin
                        low_digit <= 1'b0;
                        address   <= {address[23:0], byte_value};
                        sum       <= sum + byte_value;
                        remaining <= remaining - 8'd1;
                        addr_left <= addr_left - 3'd1;
                        // With only the checksum left the record has no data.
                        if (addr_left == 3'd1)
                            state <= (remaining == 8'd2) ? CHECK_HI : DATA;
                    end
                end
                DATA: begin
                    if (!low_digit) begin
                        high_nibble <= nibble;
                        low_digit   <= 1'b1;
                    end else begin
                        low_digit <= 1'b0;
                        if (data_record) begin
                            wr.address <= address;
                            wr.data    <= byte_value;
                            wr.enable  <= 1'b1;
                        end
                        address   <= address + 32'd1;
                        sum       <= sum + byte_value;
                        remaining <= remaining - 8'd1;
                        if (remaining == 8'd2)
                            state <= CHECK_HI;
                    end
                end
                CHECK_HI: begin
                    high_nibble <= nibble;
                    state       <= CHECK_LO;
                end
                CHECK_LO: state <= END_OF_LINE;
                END_OF_LINE: begin
                    if (end_record)
                        status.in_progress <= 1'b0;
                    state <= WAIT_S;
                end
                default: state <= WAIT_S;
            endcase
        end
    end

    write_inside_load: assert property (@(posedge HCLK) disable iff (reset)
        wr.enable |-> status.in_progress);

endmodule

//--- hdl/ahb_ram.sv
`timescale 1ns/1ns
`include "ahb_loader_config.svh"

module ahb_ram
    import ahb_loader_pkg::*;
(
    input  logic        HCLK,
    input  logic        reset,
    input  logic        sel,
    input  ahb_req_t    req,
    input  logic [31:0] hwdata,
    output ahb_resp_t   resp
);

    localparam int AW    = `RAM_ADDR_WIDTH;
    localparam int WORDS = 2 ** (AW - 2);

    logic [31:0]   mem [WORDS];
    logic          write_pending;
    logic [AW-1:0] addr_q;
    hsize_t        size_q;
    logic [3:0]    lanes;

    always_ff @(posedge HCLK) begin
        if (reset)
            write_pending <= 1'b0;
        else
            write_pending <= sel && req.hwrite;
    end

    always_ff @(posedge HCLK) begin
        if (sel) begin
            addr_q <= req.haddr[AW-1:0];
            size_q <= req.hsize;
        end
    end

    always_comb begin
        case (size_q)
            BYTE:    lanes = 4'b0001 << addr_q[1:0];
            HALF:    lanes = addr_q[1] ? 4'b1100 : 4'b0011;
            default: lanes = 4'b1111;
        endcase
    end

    // Data phase write, one cycle after the address phase.
    always_ff @(posedge HCLK) begin
        if (write_pending) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes[i])
                    mem[addr_q[AW-1:2]][8*i +: 8] <= hwdata[8*i +: 8];
            end
        end
    end

    assign resp = '{hrdata: mem[addr_q[AW-1:2]], hready: 1'b1, hresp: 1'b0};

    half_aligned: assert property (@(posedge HCLK) disable iff (reset)
        sel && req.hsize == HALF |-> !req.haddr[0]);

endmodule

//--- hdl/ahb_gpio.sv
`timescale 1ns/1ns
`include "ahb_loader_config.svh"

module ahb_gpio
    import ahb_loader_pkg::*;
(
    input  logic                        HCLK,
    input  logic                        reset,
    input  logic                        sel,
    input  ahb_req_t                    req,
    input  logic [31:0]                 hwdata,
    output ahb_resp_t                   resp,
    input  logic [`SWITCH_WIDTH-1:0]    switches,
    input  logic [`BUTTON_WIDTH-1:0]    buttons,
    output logic [`LED_RED_WIDTH-1:0]   red_leds,
    output logic [`LED_GREEN_WIDTH-1:0] green_leds
);

    logic                     write_pending;
    logic [1:0]               offset_q;
    logic [`SWITCH_WIDTH-1:0] switches_q;
    logic [`BUTTON_WIDTH-1:0] buttons_q;
    logic [31:0]              rdata;

    always_ff @(posedge HCLK) begin
        if (reset) begin
            write_pending <= 1'b0;
            red_leds      <= '0;
            green_leds    <= '0;
        end else begin
            write_pending <= sel && req.hwrite;
            if (write_pending && offset_q == 2'd0)
                red_leds <= hwdata[`LED_RED_WIDTH-1:0];
            if (write_pending && offset_q == 2'd1)
                green_leds <= hwdata[`LED_GREEN_WIDTH-1:0];
        end
    end

    always_ff @(posedge HCLK) begin
        if (sel)
            offset_q <= req.haddr[3:2];
        switches_q <= switches;
        buttons_q  <= buttons;
    end

    always_comb begin
        case (offset_q)
            2'd0:    rdata = 32'(red_leds);
            2'd1:    rdata = 32'(green_leds);
            2'd2:    rdata = 32'(switches_q);
            default: rdata = 32'(buttons_q);
        endcase
    end

    assign resp = '{hrdata: rdata, hready: 1'b1, hresp: 1'b0};

endmodule

//--- hdl/ahb_lite_matrix.sv
`timescale 1ns/1ns
`include "ahb_loader_config.svh"

module ahb_lite_matrix
    import ahb_loader_pkg::*;
(
    input  logic                        HCLK,
    input  logic                        reset,
    input  ahb_req_t                    req,
    input  logic [31:0]                 hwdata,
    output ahb_resp_t                   resp,
    input  logic [`SWITCH_WIDTH-1:0]    switches,
    input  logic [`BUTTON_WIDTH-1:0]    buttons,
    output logic [`LED_RED_WIDTH-1:0]   red_leds,
    output logic [`LED_GREEN_WIDTH-1:0] green_leds
);

    logic      active;
    logic      gpio_hit;
    logic      ram_sel;
    logic      gpio_sel;
    logic      gpio_data_phase;
    ahb_resp_t ram_resp;
    ahb_resp_t gpio_resp;

    // IDLE and BUSY transfers select no slave.
    assign active   = req.htrans == NONSEQ || req.htrans == SEQ;
    assign gpio_hit = |(req.haddr & `GPIO_BASE);
    assign ram_sel  = active && !gpio_hit;
    assign gpio_sel = active && gpio_hit;

    always_ff @(posedge HCLK) begin
        if (reset)
            gpio_data_phase <= 1'b0;
        else
            gpio_data_phase <= gpio_sel;
    end

    assign resp = gpio_data_phase ? gpio_resp : ram_resp;

    ahb_ram ram (
        .HCLK   (HCLK),
        .reset  (reset),
        .sel    (ram_sel),
        .req    (req),
        .hwdata (hwdata),
        .resp   (ram_resp)
    );

    ahb_gpio gpio (
        .HCLK       (HCLK),
        .reset      (reset),
        .sel        (gpio_sel),
        .req        (req),
        .hwdata     (hwdata),
        .resp       (gpio_resp),
        .switches   (switches),
        .buttons    (buttons),
        .red_leds   (red_leds),
        .green_leds (green_leds)
    );

endmodule

//--- hdl/ahb_lite_matrix_with_loader.sv
`timescale 1ns/1ns
`include "ahb_loader_config.svh"

module ahb_lite_matrix_with_loader
    import ahb_loader_pkg::*;
(
    input  logic                        HCLK,
    input  logic                        reset,
    input  ahb_req_t                    ext_req,
    input  logic [31:0]                 HWDATA,
    output logic [31:0]                 HRDATA,
    output logic                        HREADY,
    output logic                        HRESP,
    input  logic [`SWITCH_WIDTH-1:0]    switches,
    input  logic [`BUTTON_WIDTH-1:0]    buttons,
    output logic [`LED_RED_WIDTH-1:0]   red_leds,
    output logic [`LED_GREEN_WIDTH-1:0] green_leds,
    output logic [`LED_GREEN_WIDTH-1:0] green_status,
    input  logic                        UART_RX,
    output logic                        MFP_Reset
);

    logic [7:0]     char_data;
    logic           char_ready;
    mem_write_t     wr;
    loader_status_t status;
    ahb_req_t       loader_req;
    logic [31:0]    loader_hwdata;
    ahb_req_t       matrix_req;
    logic [31:0]    matrix_hwdata;
    ahb_resp_t      resp;

    uart_receiver receiver (
        .HCLK       (HCLK),
        .reset      (reset),
        .rx         (UART_RX),
        .char_data  (char_data),
        .char_ready (char_ready)
    );

    srec_parser parser (
        .HCLK       (HCLK),
        .reset      (reset),
        .char_data  (char_data),
        .char_ready (char_ready),
        .wr         (wr),
        .status     (status)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Loader bus master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The top two address bits are cleared so S3 loads land in the low map.
    assign loader_req = '{
        haddr:     {2'b00, wr.address[29:0]},
        htrans:    wr.enable ? NONSEQ : IDLE,
        hsize:     BYTE,
        hburst:    SINGLE,
        hprot:     4'd0,
        hmastlock: 1'b0,
        hwrite:    wr.enable
    };

    // Write data follows in the data phase on the lane of the byte address.
    always_ff @(posedge HCLK) begin
        loader_hwdata <= 32'(wr.data) << {wr.address[1:0], 3'b000};
    end

    assign matrix_req    = status.in_progress ? loader_req : ext_req;
    assign matrix_hwdata = status.in_progress ? loader_hwdata : HWDATA;

    ahb_lite_matrix matrix (
        .HCLK       (HCLK),
        .reset      (reset),
        .req        (matrix_req),
        .hwdata     (matrix_hwdata),
        .resp       (resp),
        .switches   (switches),
        .buttons    (buttons),
        .red_leds   (red_leds),
        .green_leds (green_leds)
    );

    assign HRDATA = resp.hrdata;
    assign HREADY = resp.hready;
    assign HRESP  = resp.hresp;

    assign green_status = {status.in_progress, status.format_error,
                           status.checksum_error, status.error_location[5:0]};
    assign MFP_Reset    = status.in_progress;

endmodule

//--- tests/tb_checker.sv
`timescale 1ns/1ns
`include "ahb_loader_config.svh"

module tb_checker (
    input  logic                        HCLK,
    input  logic [8*16-1:0]             test_name,
    input  logic                        read_check,
    input  logic [31:0]                 expect_word,
    input  logic                        status_check,
    input  logic [8:0]                  expect_status,
    input  logic                        led_check,
    input  logic [`LED_RED_WIDTH-1:0]   expect_red,
    input  logic [`LED_GREEN_WIDTH-1:0] expect_green,
    input  logic [31:0]                 HRDATA,
    input  logic                        HREADY,
    input  logic                        HRESP,
    input  logic [8:0]                  green_status,
    input  logic                        MFP_Reset,
    input  logic [`LED_RED_WIDTH-1:0]   red_leds,
    input  logic [`LED_GREEN_WIDTH-1:0] green_leds,
    output int                          check_count,
    output int                          error_count
);

    logic        data_phase;
    logic [31:0] word_q;
    logic        mfp_reset_q;
    int          load_starts;
    int          load_ends;

    initial begin
        check_count = 0;
        error_count = 0;
        load_starts = 0;
        load_ends   = 0;
        mfp_reset_q = 1'b0;
        data_phase  = 1'b0;
    end

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0s %0s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    // The read issued in the address phase is checked one cycle later.
    always @(posedge HCLK) begin
        data_phase <= read_check;
        word_q     <= expect_word;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sampling on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge HCLK) begin
        if (MFP_Reset === 1'b1 && !mfp_reset_q)
            load_starts++;
        if (MFP_Reset === 1'b0 && mfp_reset_q)
            load_ends++;
        mfp_reset_q = (MFP_Reset === 1'b1);

        // Both slaves are zero-wait and never signal an error.
        if (data_phase) begin
            compare("read data", word_q, HRDATA);
            compare("hready", 32'd1, 32'(HREADY));
            compare("hresp", 32'd0, 32'(HRESP));
        end
        // One load per case means MFP_Reset never dropped before the last record.
        if (status_check) begin
            compare("loader status", 32'(expect_status), 32'(green_status));
            compare("load starts", 32'd1, 32'(load_starts));
            compare("load ends", 32'd1, 32'(load_ends));
            load_starts = 0;
            load_ends   = 0;
        end
        if (led_check) begin
            compare("red leds", 32'(expect_red), 32'(red_leds));
            compare("green leds", 32'(expect_green), 32'(green_leds));
        end
    end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/1ns
`include "ahb_loader_config.svh"

module tb_top
    import ahb_loader_pkg::*;
();

    localparam int         NCASES    = 6;
    localparam int         LOAD_WAIT = 200;
    localparam logic [1:0] NO_FAULT  = 2'd0;
    localparam logic [1:0] BAD_SUM   = 2'd1;
    localparam logic [1:0] BAD_HEX   = 2'd2;

    // One load: a data record, then either a terminator or a faulty second record.
    typedef struct packed {
        logic [8*16-1:0] name;
        logic [7:0]      rec_type;
        logic [31:0]     base;
        logic [31:0]     word;
        logic [1:0]      fault;
    } load_case_t;

    logic                        HCLK;
    logic                        reset;
    ahb_req_t                    ext_req;
    logic [31:0]                 HWDATA;
    logic [31:0]                 HRDATA;
    logic                        HREADY;
    logic                        HRESP;
    logic [`SWITCH_WIDTH-1:0]    switches;
    logic [`BUTTON_WIDTH-1:0]    buttons;
    logic [`LED_RED_WIDTH-1:0]   red_leds;
    logic [`LED_GREEN_WIDTH-1:0] green_leds;
    logic [8:0]                  green_status;
    logic                        UART_RX;
    logic                        MFP_Reset;

    logic [8*16-1:0]             test_name;
    logic                        read_check;
    logic [31:0]                 expect_word;
    logic                        status_check;
    logic [8:0]                  expect_status;
    logic                        led_check;
    logic [`LED_RED_WIDTH-1:0]   expect_red;
    logic [`LED_GREEN_WIDTH-1:0] expect_green;
    int                          check_count;
    int                          error_count;
    load_case_t                  cases [NCASES];
    string                       text;

    ahb_lite_matrix_with_loader UUT (
        .HCLK(HCLK), .reset(reset), .ext_req(ext_req), .HWDATA(HWDATA),
        .HRDATA(HRDATA), .HREADY(HREADY), .HRESP(HRESP),
        .switches(switches), .buttons(buttons), .red_leds(red_leds),
        .green_leds(green_leds), .green_status(green_status),
        .UART_RX(UART_RX), .MFP_Reset(MFP_Reset)
    );

    tb_checker scoreboard (
        .HCLK(HCLK), .test_name(test_name),
        .read_check(read_check), .expect_word(expect_word),
        .status_check(status_check), .expect_status(expect_status),
        .led_check(led_check), .expect_red(expect_red), .expect_green(expect_green),
        .HRDATA(HRDATA), .HREADY(HREADY), .HRESP(HRESP),
        .green_status(green_status), .MFP_Reset(MFP_Reset),
        .red_leds(red_leds), .green_leds(green_leds),
        .check_count(check_count), .error_count(error_count)
    );

    always #20 HCLK = ~HCLK;

    task automatic next_cycle();
        @(posedge HCLK);
        #5;
    endtask

    function automatic load_case_t make_case(input logic [8*16-1:0] name,
                                             input logic [7:0] rec_type,
                                             input logic [31:0] base,
                                             input logic [31:0] word,
                                             input logic [1:0] fault);
        return '{name: name, rec_type: rec_type, base: base, word: word, fault: fault};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // S-record text
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic string record_line(input logic [7:0] rec_type,
                                          input logic [31:0] address,
                                          input logic [31:0] word,
                                          input logic with_data,
                                          input logic [1:0] fault);
        int         addr_bytes;
        logic [7:0] count;
        logic [7:0] sum;
        string      s;
        addr_bytes = (rec_type == "3" || rec_type == "7") ? 4 : 2;
        count = 8'(addr_bytes + (with_data ? 5 : 1));
        sum = count;
        s = $sformatf("S%c%02X", rec_type, count);
        for (int i = addr_bytes - 1; i >= 0; i--) begin
            sum += address[8*i +: 8];
            s = {s, $sformatf("%02X", address[8*i +: 8])};
        end
        if (with_data) begin
            for (int i = 0; i < 4; i++) begin
                sum += word[8*i +: 8];
                s = {s, $sformatf("%02X", word[8*i +: 8])};
            end
        end
        // The checksum byte is the one's complement of the low byte of the sum.
        sum = ~sum;
        if (fault == BAD_SUM)
            sum ^= 8'h01;
        s = {s, $sformatf("%02X", sum), "\r\n"};
        if (fault == BAD_HEX)
            s.putc(4 + 2 * addr_bytes, "G");
        return s;
    endfunction

    function automatic string build_text(input load_case_t lc);
        string s;
        s = record_line(lc.rec_type, lc.base, lc.word, 1'b1, NO_FAULT);
        if (lc.fault == NO_FAULT)
            s = {s, record_line((lc.rec_type == "3") ? "7" : "9", 32'd0, 32'd0, 1'b0,
                                NO_FAULT)};
        else
            s = {s, record_line(lc.rec_type, lc.base + 32'd4, lc.word, 1'b1, lc.fault)};
        return s;
    endfunction

    task automatic send_char(input logic [7:0] value);
        UART_RX = 1'b0;
        repeat (`CLKS_PER_BIT) next_cycle();
        for (int i = 0; i < 8; i++) begin
            UART_RX = value[i];
            repeat (`CLKS_PER_BIT) next_cycle();
        end
        // Stop bit, then one idle bit.
        UART_RX = 1'b1;
        repeat (2 * `CLKS_PER_BIT) next_cycle();
    endtask

    task automatic wait_load_end();
        int cycles;
        cycles = 0;
        while (MFP_Reset !== 1'b0 && cycles < LOAD_WAIT) begin
            next_cycle();
            cycles++;
        end
        if (MFP_Reset !== 1'b0) begin
            $display("Timeout: MFP_Reset stayed high after the load of %0s", test_name);
            $display("Some tests failed");
            $finish;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // External master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic bus_write(input logic [31:0] address, input logic [31:0] value);
        ext_req.haddr  = address;
        ext_req.htrans = NONSEQ;
        ext_req.hwrite = 1'b1;
        next_cycle();
        ext_req.htrans = IDLE;
        ext_req.hwrite = 1'b0;
        HWDATA         = value;
        next_cycle();
    endtask

    task automatic bus_read(input logic [31:0] address, input logic [31:0] expected);
        ext_req.haddr  = address;
        ext_req.htrans = NONSEQ;
        read_check     = 1'b1;
        expect_word    = expected;
        next_cycle();
        ext_req.htrans = IDLE;
        read_check     = 1'b0;
        next_cycle();
    endtask

    initial begin
        void'($urandom(41059));
        HCLK          = 1'b0;
        reset         = 1'b1;
        UART_RX       = 1'b1;
        HWDATA        = 32'd0;
        switches      = $urandom;
        buttons       = $urandom;
        test_name     = "reset";
        read_check    = 1'b0;
        expect_word   = 32'd0;
        status_check  = 1'b0;
        expect_status = 9'd0;
        led_check     = 1'b0;
        expect_red    = '0;
        expect_green  = '0;
        ext_req = '{haddr: 32'd0, htrans: IDLE, hsize: WORD, hburst: SINGLE,
                    hprot: 4'd0, hmastlock: 1'b0, hwrite: 1'b0};

        cases[0] = make_case("s1_basic", "1", 32'h0000_0010, 32'h4433_2211, NO_FAULT);
        cases[1] = make_case("s1_random", "1", 32'h0000_0080, $urandom, NO_FAULT);
        cases[2] = make_case("s3_high_address", "3", 32'hC000_0204, 32'hDEAD_BEEF, NO_FAULT);
        cases[3] = make_case("bad_checksum", "1", 32'h0000_0100, 32'hA5A5_5A5A, BAD_SUM);
        cases[4] = make_case("bad_hex_digit", "1", 32'h0000_0140, 32'h0102_0304, BAD_HEX);
        cases[5] = make_case("reload_ok", "3", 32'h0000_0300, 32'h89AB_CDEF, NO_FAULT);

        repeat (3) @(posedge HCLK);
        #5;
        reset = 1'b0;
        next_cycle();

        for (int c = 0; c < NCASES; c++) begin
            test_name = cases[c].name;
            text = build_text(cases[c]);
            for (int i = 0; i < text.len(); i++)
                send_char(text.getc(i));
            wait_load_end();
            // A fault always sits in the second record line.
            status_check  = 1'b1;
            expect_status = {1'b0, cases[c].fault == BAD_HEX, cases[c].fault == BAD_SUM,
                             (cases[c].fault == NO_FAULT) ? 6'd0 : 6'd2};
            next_cycle();
            status_check = 1'b0;
            bus_read({2'b00, cases[c].base[29:0]}, cases[c].word);
        end

        test_name    = "gpio_registers";
        expect_red   = $urandom;
        expect_green = $urandom;
        bus_write(`GPIO_BASE, 32'(expect_red));
        bus_write(`GPIO_BASE + 32'h4, 32'(expect_green));
        led_check = 1'b1;
        next_cycle();
        led_check = 1'b0;
        bus_read(`GPIO_BASE, 32'(expect_red));
        bus_read(`GPIO_BASE + 32'h4, 32'(expect_green));
        bus_read(`GPIO_BASE + 32'h8, 32'(switches));
        bus_read(`GPIO_BASE + 32'hC, 32'(buttons));

        repeat (2) next_cycle();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+hdl
hdl/ahb_loader_pkg.sv
hdl/uart_receiver.sv
hdl/srec_parser.sv
hdl/ahb_ram.sv
hdl/ahb_gpio.sv
hdl/ahb_lite_matrix.sv
hdl/ahb_lite_matrix_with_loader.sv
tests/tb_checker.sv
tests/tb_top.sv
